/* Bender.yml */
package:
  name: mipsCore

sources:
  - hdl/mipsIsaPkg.sv
  - hdl/mipsCtrlPkg.sv
  - hdl/control.sv
  - hdl/nextPc.sv
  - hdl/regFile.sv
  - hdl/execute.sv
  - hdl/dataMem.sv
  - hdl/mipsCore.sv
  - target: simulation
    files:
      - dv/mipsCoreTb.sv

/* dv/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

    localparam int cycleLimit = 2000;
    localparam int progDepth  = 256;

    logic                  clk;
    logic                  reset;
    logic [31:0]           pc;
    mipsIsaPkg::instrWord  instr;
    mipsCtrlPkg::regCommit regWb;
    mipsCtrlPkg::memCommit memWb;

    logic [31:0] prog [0:progDepth-1];
    logic [31:0] progIdx;
    int          progLen;

    // Reference model state
    logic [31:0] refRegs [0:31];
    logic [31:0] refMem [0:1023];
    logic [31:0] refPc;

    logic [31:0] lcgState;
    int          cycles;
    int          pcErrs;
    int          regErrs;
    int          memErrs;
    int          otherErrs;

    mipsCore u_mipsCore (
        .clk   (clk),
        .reset (reset),
        .pc    (pc),
        .instr (instr),
        .regWb (regWb),
        .memWb (memWb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Instruction memory, answers in the same cycle
    assign progIdx = (pc - mipsIsaPkg::resetVector) >> 2;

    always_comb begin
        if (progIdx < progDepth) begin
            instr = prog[progIdx];
        end else begin
            instr = '0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("Timeout, run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Upper LCG bits are the better ones
    function automatic logic [4:0] pickReg(input logic [31:0] v);
        return 5'((v >> 16) % 7) + 5'd1;
    endfunction

    function automatic logic [31:0] signExt(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [31:0] rInstr(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] func);
        return {mipsIsaPkg::opRType, rs, rt, rd, 5'd0, func};
    endfunction

    function automatic logic [31:0] immInstr(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jumpInstr(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // Reset goes high before the new program replaces the old one
    task automatic startProgram();
        @(posedge clk);
        #0.5;
        reset = 1'b1;
        progLen = 0;
        for (int i = 0; i < progDepth; i++) begin
            prog[i] = '0;
        end
    endtask

    //////////////////////////////
    // Reference model and checks
    //////////////////////////////
    task automatic checkStep(input string name);
        mipsIsaPkg::instrWord  w;
        mipsCtrlPkg::regCommit expReg;
        mipsCtrlPkg::memCommit expMem;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] addr;
        logic [31:0] npc;
        w      = prog[(refPc - mipsIsaPkg::resetVector) >> 2];
        rsVal  = refRegs[w.rFmt.rs];
        rtVal  = refRegs[w.rFmt.rt];
        expReg = '0;
        expMem = '0;
        npc    = refPc + 32'd4;
        addr   = rsVal + signExt(w.iFmt.imm16);
        case (w.rFmt.opCode)
            mipsIsaPkg::opRType: begin
                if (w.rFmt.func == mipsIsaPkg::fnAddu) begin
                    expReg = {1'b1, w.rFmt.rd, rsVal + rtVal};
                end else if (w.rFmt.func == mipsIsaPkg::fnSubu) begin
                    expReg = {1'b1, w.rFmt.rd, rsVal - rtVal};
                end else if (w.rFmt.func == mipsIsaPkg::fnJr) begin
                    npc = rsVal;
                end
            end
            mipsIsaPkg::opOri: expReg = {1'b1, w.iFmt.rt, rsVal | {16'd0, w.iFmt.imm16}};
            mipsIsaPkg::opLui: expReg = {1'b1, w.iFmt.rt, w.iFmt.imm16, 16'd0};
            mipsIsaPkg::opLw:  expReg = {1'b1, w.iFmt.rt, refMem[int'(addr[11:2])]};
            mipsIsaPkg::opSw:  expMem = {1'b1, addr, rtVal};
            mipsIsaPkg::opBeq: begin
                if (rsVal == rtVal) begin
                    npc = refPc + 32'd4 + (signExt(w.iFmt.imm16) << 2);
                end
            end
            mipsIsaPkg::opJal: begin
                expReg = {1'b1, 5'd31, refPc + 32'd4};
                npc    = {npc[31:28], w.jFmt.index26, 2'b00};
            end
            default: ;
        endcase
        // Writes to register 0 vanish
        if (expReg.addr == 5'd0) begin
            expReg.valid = 1'b0;
        end
        if (pc !== refPc) begin
            $display("FAILED %s pc: expected %h, actual %h", name, refPc, pc);
            pcErrs++;
        end
        if (regWb.valid !== expReg.valid || (expReg.valid && regWb !== expReg)) begin
            $display("FAILED %s regWb: expected %h, actual %h", name, expReg, regWb);
            regErrs++;
        end
        if (memWb.valid !== expMem.valid || (expMem.valid && memWb !== expMem)) begin
            $display("FAILED %s memWb: expected %h, actual %h", name, expMem, memWb);
            memErrs++;
        end
        if (expReg.valid) begin
            refRegs[expReg.addr] = expReg.data;
        end
        if (expMem.valid) begin
            refMem[int'(expMem.addr[11:2])] = expMem.data;
        end
        refPc = npc;
    endtask

    // Finishes the reset pulse, then steps until the model falls off the program
    task automatic runProgram(input string name);
        logic [31:0] stopPc;
        stopPc = mipsIsaPkg::resetVector + 32'(progLen * 4);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (regWb.valid !== 1'b0 || memWb.valid !== 1'b0) begin
                $display("A commit was reported valid while reset was high in %s", name);
                otherErrs++;
            end
            if (i > 0 && pc !== mipsIsaPkg::resetVector) begin
                $display("FAILED %s reset pc: expected %h, actual %h", name,
                         mipsIsaPkg::resetVector, pc);
                pcErrs++;
            end
        end
        @(posedge clk);
        #0.5;
        reset = 1'b0;
        for (int r = 0; r < 32; r++) begin
            refRegs[r] = '0;
        end
        refPc = mipsIsaPkg::resetVector;
        while (refPc != stopPc) begin
            @(negedge clk);
            checkStep(name);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic resetSequence();
        startProgram();
        // A store waits at the reset vector while reset is high
        emit(immInstr(mipsIsaPkg::opSw, 5'd0, 5'd0, 16'h0040));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd1, 16'h00ff));
        emit(rInstr(5'd1, 5'd1, 5'd2, mipsIsaPkg::fnAddu));
        runProgram("reset");
    endtask

    task automatic arithOps();
        logic [31:0] a;
        logic [31:0] b;
        a = nextRand();
        b = nextRand();
        startProgram();
        emit(immInstr(mipsIsaPkg::opLui, 5'd0, 5'd1, a[31:16]));
        emit(immInstr(mipsIsaPkg::opOri, 5'd1, 5'd1, a[15:0]));
        emit(immInstr(mipsIsaPkg::opLui, 5'd0, 5'd2, b[31:16]));
        emit(immInstr(mipsIsaPkg::opOri, 5'd2, 5'd2, b[15:0]));
        emit(rInstr(5'd1, 5'd2, 5'd3, mipsIsaPkg::fnAddu));
        emit(rInstr(5'd1, 5'd2, 5'd4, mipsIsaPkg::fnSubu));
        emit(rInstr(5'd2, 5'd1, 5'd5, mipsIsaPkg::fnSubu));
        // All ones plus a wraps around
        emit(immInstr(mipsIsaPkg::opLui, 5'd0, 5'd6, 16'hffff));
        emit(immInstr(mipsIsaPkg::opOri, 5'd6, 5'd6, 16'hffff));
        emit(rInstr(5'd6, 5'd1, 5'd7, mipsIsaPkg::fnAddu));
        emit(rInstr(5'd1, 5'd2, 5'd0, mipsIsaPkg::fnAddu));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd0, 16'h0055));
        emit(rInstr(5'd0, 5'd0, 5'd8, mipsIsaPkg::fnAddu));
        // Unknown function code, r9 must stay zero
        emit(rInstr(5'd1, 5'd2, 5'd9, 6'h3f));
        emit(rInstr(5'd9, 5'd0, 5'd10, mipsIsaPkg::fnAddu));
        runProgram("arith");
    endtask

    task automatic memoryAccess();
        logic [31:0] d;
        logic [31:0] e;
        d = nextRand();
        e = nextRand();
        startProgram();
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd1, 16'h0100));
        emit(immInstr(mipsIsaPkg::opLui, 5'd0, 5'd2, d[31:16]));
        emit(immInstr(mipsIsaPkg::opOri, 5'd2, 5'd2, d[15:0]));
        emit(immInstr(mipsIsaPkg::opLui, 5'd0, 5'd3, e[31:16]));
        emit(immInstr(mipsIsaPkg::opSw, 5'd1, 5'd2, 16'h0008));
        emit(immInstr(mipsIsaPkg::opSw, 5'd1, 5'd3, 16'hfffc));
        emit(immInstr(mipsIsaPkg::opLw, 5'd1, 5'd4, 16'h0008));
        emit(immInstr(mipsIsaPkg::opLw, 5'd1, 5'd5, 16'hfffc));
        emit(rInstr(5'd4, 5'd5, 5'd6, mipsIsaPkg::fnAddu));
        runProgram("memory");
    endtask

    // Path 0,1,2,5,6,7,10,8,9,12
    task automatic branchFlow();
        startProgram();
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd1, 16'd5));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd2, 16'd5));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd1, 5'd2, 16'd2));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd3, 16'd1));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd3, 16'd2));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd1, 5'd0, 16'd1));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd4, 16'd3));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'd2));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd5, 16'd7));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'd2));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'hfffd));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd6, 16'd9));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd7, 16'd4));
        runProgram("branch");
    endtask

    // Subroutine at word 4 returns to word 2
    task automatic jumpAndReturn();
        startProgram();
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd1, 16'd1));
        emit(jumpInstr(mipsIsaPkg::opJal, mipsIsaPkg::resetVector + 32'd16));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd2, 16'd2));
        emit(immInstr(mipsIsaPkg::opBeq, 5'd0, 5'd0, 16'd2));
        emit(immInstr(mipsIsaPkg::opOri, 5'd0, 5'd3, 16'd3));
        emit(rInstr(5'd31, 5'd0, 5'd0, mipsIsaPkg::fnJr));
        runProgram("jump");
    endtask

    task automatic randomMix();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        startProgram();
        for (int i = 0; i < 200; i++) begin
            rs = pickReg(nextRand());
            rt = pickReg(nextRand());
            rd = pickReg(nextRand());
            r  = nextRand();
            case (r[17:16])
                2'd0: emit(rInstr(rs, rt, rd, mipsIsaPkg::fnAddu));
                2'd1: emit(rInstr(rs, rt, rd, mipsIsaPkg::fnSubu));
                2'd2: emit(immInstr(mipsIsaPkg::opOri, rs, rt, r[31:16]));
                default: emit(immInstr(mipsIsaPkg::opLui, 5'd0, rt, r[31:16]));
            endcase
        end
        runProgram("random");
    endtask

    initial begin
        reset     = 1'b1;
        lcgState  = 32'd20;
        cycles    = 0;
        pcErrs    = 0;
        regErrs   = 0;
        memErrs   = 0;
        otherErrs = 0;
        progLen   = 0;
        refPc     = mipsIsaPkg::resetVector;
        for (int i = 0; i < progDepth; i++) begin
            prog[i] = '0;
        end
        resetSequence();
        arithOps();
        memoryAccess();
        branchFlow();
        jumpAndReturn();
        randomMix();
        $display("Errors: pc %0d, regWb %0d, memWb %0d, other %0d",
                 pcErrs, regErrs, memErrs, otherErrs);
        if (pcErrs + regErrs + memErrs + otherErrs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* hdl/control.sv */
`timescale 1ns/1ps

module control (
    input  mipsIsaPkg::instrWord   instr,
    output mipsCtrlPkg::ctrlBundle ctrl
);

    logic [5:0] opCode;
    logic [5:0] func;
    logic       rType;
    logic       addu, subu, jr;
    logic       beq, jal, lui, lw, ori, sw;
    mipsCtrlPkg::ctrlBundle decoded;

    assign opCode = instr.rFmt.opCode;
    assign func   = instr.rFmt.func;

    ///////////////////////////////
    // One flag per instruction
    ///////////////////////////////
    assign rType = (opCode == mipsIsaPkg::opRType);
    assign addu  = rType && (func == mipsIsaPkg::fnAddu);
    assign subu  = rType && (func == mipsIsaPkg::fnSubu);
    assign jr    = rType && (func == mipsIsaPkg::fnJr);
    assign beq   = (opCode == mipsIsaPkg::opBeq);
    assign jal   = (opCode == mipsIsaPkg::opJal);
    assign lui   = (opCode == mipsIsaPkg::opLui);
    assign lw    = (opCode == mipsIsaPkg::opLw);
    assign ori   = (opCode == mipsIsaPkg::opOri);
    assign sw    = (opCode == mipsIsaPkg::opSw);

    // Each field is an OR of the flags that need it
    always_comb begin
        decoded               = '0;
        decoded.npcOp[1]      = jal || jr;
        decoded.npcOp[0]      = beq || jr;
        decoded.regWrite      = addu || subu || ori || lw || lui || jal;
        decoded.extOp[1]      = lui;
        decoded.extOp[0]      = lw || sw;
        decoded.aluOp[1]      = ori;
        decoded.aluOp[0]      = subu;
        decoded.memWrite      = sw;
        decoded.regA3Sel[1]   = jal;
        decoded.regA3Sel[0]   = ori || lw || lui;
        decoded.regDataSel[1] = jal || lui;
        decoded.regDataSel[0] = lw || jal;
        decoded.aluBSel[0]    = ori || lw || sw;
    end

    // Anything outside the subset raises no flag and retires as nop
    assign ctrl = decoded;

endmodule

/* hdl/dataMem.sv */
`timescale 1ns/1ps

module dataMem (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wrEn,
    input  logic [31:0]           addr,
    input  logic [31:0]           wrData,
    output logic [31:0]           rdData,
    output mipsCtrlPkg::memCommit commit
);

    logic [31:0] mem [0:1023];
    logic [9:0]  wordIdx;
    logic        doWrite;

    // Word addressed, low two bits ignored
    assign wordIdx = addr[11:2];
    assign doWrite = wrEn && !reset;

    assign rdData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign commit.valid = doWrite;
    assign commit.addr  = addr;
    assign commit.data  = wrData;

endmodule

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  mipsCtrlPkg::ctrlBundle ctrl,
    input  logic [15:0]            imm16,
    input  logic [31:0]            rsData,
    input  logic [31:0]            rtData,
    output logic [31:0]            extImm,
    output logic [31:0]            aluResult,
    output logic                   equal
);

    logic [31:0] aluB;

    ///////////////////////////////
    // Immediate extension
    ///////////////////////////////
    always_comb begin
        case (ctrl.extOp)
            mipsCtrlPkg::extSign: begin
                extImm = {{16{imm16[15]}}, imm16};
            end
            mipsCtrlPkg::extUpper: begin
                extImm = {imm16, 16'd0};
            end
            default: begin
                extImm = {16'd0, imm16};
            end
        endcase
    end

    assign aluB = (ctrl.aluBSel == mipsCtrlPkg::bImm) ? extImm : rtData;

    ///////////////////////////////
    // ALU
    ///////////////////////////////
    always_comb begin
        case (ctrl.aluOp)
            mipsCtrlPkg::aluSub: begin
                aluResult = rsData - aluB;
            end
            mipsCtrlPkg::aluOr: begin
                aluResult = rsData | aluB;
            end
            default: begin
                aluResult = rsData + aluB;
            end
        endcase
    end

    // Branch compare works on the registers, not the ALU
    assign equal = (rsData == rtData);

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore (
    input  logic                  clk,
    input  logic                  reset,
    output logic [31:0]           pc,
    input  mipsIsaPkg::instrWord  instr,
    output mipsCtrlPkg::regCommit regWb,
    output mipsCtrlPkg::memCommit memWb
);

    mipsCtrlPkg::ctrlBundle ctrl;
    logic [31:0] pcPlus4;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] extImm;
    logic [31:0] aluResult;
    logic [31:0] memRdData;
    logic        equal;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    control u_control (
        .instr (instr),
        .ctrl  (ctrl)
    );

    nextPc u_nextPc (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .instr   (instr),
        .equal   (equal),
        .rsData  (rsData),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    regFile u_regFile (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (instr.rFmt.rs),
        .rtAddr (instr.rFmt.rt),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .commit (regWb)
    );

    execute u_execute (
        .ctrl      (ctrl),
        .imm16     (instr.iFmt.imm16),
        .rsData    (rsData),
        .rtData    (rtData),
        .extImm    (extImm),
        .aluResult (aluResult),
        .equal     (equal)
    );

    dataMem u_dataMem (
        .clk    (clk),
        .reset  (reset),
        .wrEn   (ctrl.memWrite),
        .addr   (aluResult),
        .wrData (rtData),
        .rdData (memRdData),
        .commit (memWb)
    );

    ///////////////////////////////
    // Write-back
    ///////////////////////////////
    assign wrEn = ctrl.regWrite && !reset;

    always_comb begin
        case (ctrl.regA3Sel)
            mipsCtrlPkg::a3Rt: wrAddr = instr.rFmt.rt;
            mipsCtrlPkg::a3Ra: wrAddr = 5'd31;
            default:           wrAddr = instr.rFmt.rd;
        endcase
    end

    // Link value is pc+4, no delay slot
    always_comb begin
        case (ctrl.regDataSel)
            mipsCtrlPkg::wdMem:   wrData = memRdData;
            mipsCtrlPkg::wdUpper: wrData = extImm;
            mipsCtrlPkg::wdLink:  wrData = pcPlus4;
            default:              wrData = aluResult;
        endcase
    end

endmodule

/* hdl/mipsCtrlPkg.sv */
package mipsCtrlPkg;

    // Next-PC select, bit 1 jump-type, bit 0 branch or register
    localparam logic [1:0] npcSeq    = 2'b00;
    localparam logic [1:0] npcBranch = 2'b01;
    localparam logic [1:0] npcJump   = 2'b10;
    localparam logic [1:0] npcReg    = 2'b11;

    // Immediate extension
    localparam logic [1:0] extZero  = 2'b00;
    localparam logic [1:0] extSign  = 2'b01;
    localparam logic [1:0] extUpper = 2'b10;

    // ALU operation
    localparam logic [3:0] aluAdd = 4'b0000;
    localparam logic [3:0] aluSub = 4'b0001;
    localparam logic [3:0] aluOr  = 4'b0010;

    // Destination register select
    localparam logic [1:0] a3Rd = 2'b00;
    localparam logic [1:0] a3Rt = 2'b01;
    localparam logic [1:0] a3Ra = 2'b10;

    // Write-back data select
    localparam logic [1:0] wdAlu   = 2'b00;
    localparam logic [1:0] wdMem   = 2'b01;
    localparam logic [1:0] wdUpper = 2'b10;
    localparam logic [1:0] wdLink  = 2'b11;

    // ALU B operand
    localparam logic [1:0] bReg = 2'b00;
    localparam logic [1:0] bImm = 2'b01;

    ///////////////////////////////
    // Bundles
    ///////////////////////////////
    typedef struct packed {
        logic [1:0] npcOp;
        logic       regWrite;
        logic [1:0] extOp;
        logic [3:0] aluOp;
        logic       memWrite;
        logic [1:0] regA3Sel;
        logic [1:0] regDataSel;
        logic [1:0] aluBSel;
    } ctrlBundle;

    typedef struct packed {
        logic        valid;
        logic [4:0]  addr;
        logic [31:0] data;
    } regCommit;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
    } memCommit;

endpackage

/* hdl/mipsIsaPkg.sv */
package mipsIsaPkg;

    ///////////////////////////////
    // Opcodes
    ///////////////////////////////
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opJal   = 6'b000011;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opSw    = 6'b101011;

    // Function field of the R-type subset
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnNop  = 6'b000000;

    // First fetch address out of reset
    localparam logic [31:0] resetVector = 32'h0000_3000;

    ///////////////////////////////
    // Instruction formats
    ///////////////////////////////
    typedef struct packed {
        logic [5:0] opCode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } rFormat;

    typedef struct packed {
        logic [5:0]  opCode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFormat;

    typedef struct packed {
        logic [5:0]  opCode;
        logic [25:0] index26;
    } jFormat;

    // One fetched word, viewed in whichever format the opcode implies
    typedef union packed {
        rFormat rFmt;
        iFormat iFmt;
        jFormat jFmt;
    } instrWord;

endpackage

/* hdl/nextPc.sv */
`timescale 1ns/1ps

module nextPc (
    input  logic                   clk,
    input  logic                   reset,
    input  mipsCtrlPkg::ctrlBundle ctrl,
    input  mipsIsaPkg::instrWord   instr,
    input  logic                   equal,
    input  logic [31:0]            rsData,
    output logic [31:0]            pc,
    output logic [31:0]            pcPlus4
);

    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] npc;

    assign pcPlus4 = pc + 32'd4;

    // Word offset, sign-extended
    assign branchOffset = {{14{instr.iFmt.imm16[15]}}, instr.iFmt.imm16, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // Stays inside the current 256 MB region
    assign jumpTarget = {pcPlus4[31:28], instr.jFmt.index26, 2'b00};

    ///////////////////////////////
    // Next address select
    ///////////////////////////////
    always_comb begin
        case (ctrl.npcOp)
            mipsCtrlPkg::npcBranch: begin
                npc = equal ? branchTarget : pcPlus4;
            end
            mipsCtrlPkg::npcJump: begin
                npc = jumpTarget;
            end
            mipsCtrlPkg::npcReg: begin
                npc = rsData;
            end
            default: begin
                npc = pcPlus4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsIsaPkg::resetVector;
        end else begin
            pc <= npc;
        end
    end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [4:0]            rsAddr,
    input  logic [4:0]            rtAddr,
    output logic [31:0]           rsData,
    output logic [31:0]           rtData,
    input  logic                  wrEn,
    input  logic [4:0]            wrAddr,
    input  logic [31:0]           wrData,
    output mipsCtrlPkg::regCommit commit
);

    logic [31:0] regs [0:31];
    logic        doWrite;

    // Register 0 is never stored
    assign doWrite = wrEn && (wrAddr != 5'd0);

    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (doWrite) begin
            regs[wrAddr] <= wrData;
        end
    end

    // The write this edge performs
    assign commit.valid = doWrite;
    assign commit.addr  = wrAddr;
    assign commit.data  = wrData;

endmodule

/* verilog.f */
hdl/mipsIsaPkg.sv
hdl/mipsCtrlPkg.sv
hdl/control.sv
hdl/nextPc.sv
hdl/regFile.sv
hdl/execute.sv
hdl/dataMem.sv
hdl/mipsCore.sv
dv/mipsCoreTb.sv
